// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_fpga -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_fpga); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== rtl/fpga.sv ====
`timescale 1ns/1ps

module fpga #(
    parameter int PRESCALE = 3,
    parameter int INVERT   = 1
) (
    input  logic                                    clk,
    input  logic                                    arst_n,

    // register requests
    input  logic                                    req_valid,
    input  pcie_req_pkg::req_word_u                 req_data,
    output logic                                    req_ready,

    // read completions
    output logic                                    cpl_valid,
    output logic [pcie_req_pkg::TAG_W-1:0]          cpl_tag,
    output logic [pcie_req_pkg::CPL_DATA_W-1:0]     cpl_data,
    input  logic                                    cpl_ready,

    // board leds
    output logic [led_pkg::LED_AUX_W-1:0]           led_bmc,
    output logic [led_pkg::LED_AUX_W-1:0]           led_exp,
    output logic                                    led_sreg_d,
    output logic                                    led_sreg_ld,
    output logic                                    led_sreg_clk
);

    import pcie_req_pkg::*;
    import led_pkg::*;

    logic                     dec_valid;
    logic                     dec_ready;
    logic                     dec_write;
    logic [ADDR_W-1:0]        dec_addr;
    logic [CPL_DATA_W-1:0]    dec_wdata;
    logic [TAG_W-1:0]         dec_tag;
    logic [LED_RGB_COUNT-1:0] led_red;
    logic [LED_RGB_COUNT-1:0] led_green;
    logic [SREG_COUNT-1:0]    led_merged;

    req_decode req_decode_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_data  (req_data),
        .req_ready (req_ready),
        .dec_valid (dec_valid),
        .dec_write (dec_write),
        .dec_addr  (dec_addr),
        .dec_wdata (dec_wdata),
        .dec_tag   (dec_tag),
        .dec_ready (dec_ready)
    );

    led_regs led_regs_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec_write (dec_write),
        .dec_addr  (dec_addr),
        .dec_wdata (dec_wdata),
        .dec_tag   (dec_tag),
        .dec_ready (dec_ready),
        .cpl_valid (cpl_valid),
        .cpl_tag   (cpl_tag),
        .cpl_data  (cpl_data),
        .cpl_ready (cpl_ready),
        .led_red   (led_red),
        .led_green (led_green),
        .led_bmc   (led_bmc),
        .led_exp   (led_exp)
    );

    // each bicolour led takes a red/green pair on the chain
    for (genvar i = 0; i < LED_RGB_COUNT; i++) begin : g_merge
        assign led_merged[2*i]   = led_red[i];
        assign led_merged[2*i+1] = led_green[i];
    end

    led_sreg_driver #(
        .PRESCALE (PRESCALE),
        .INVERT   (INVERT)
    ) led_sreg_driver_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .led      (led_merged),
        .sreg_d   (led_sreg_d),
        .sreg_ld  (led_sreg_ld),
        .sreg_clk (led_sreg_clk)
    );

endmodule

// ==== rtl/led_pkg.sv ====
package led_pkg;

    // register map
    localparam logic [3:0] ADDR_LED_RED   = 4'd0;
    localparam logic [3:0] ADDR_LED_GREEN = 4'd1;
    localparam logic [3:0] ADDR_LED_BMC   = 4'd2;
    localparam logic [3:0] ADDR_LED_EXP   = 4'd3;

    // leds per colour on the front panel
    localparam int LED_RGB_COUNT = 8;

    // bmc and expansion status leds
    localparam int LED_AUX_W = 2;

    // one frame on the shift register, red and green interleaved
    localparam int SREG_COUNT = 2 * LED_RGB_COUNT;

endpackage

// ==== rtl/led_regs.sv ====
`timescale 1ns/1ps

module led_regs (
    input  logic                                    clk,
    input  logic                                    arst_n,

    input  logic                                    dec_valid,
    input  logic                                    dec_write,
    input  logic [pcie_req_pkg::ADDR_W-1:0]         dec_addr,
    input  logic [pcie_req_pkg::CPL_DATA_W-1:0]     dec_wdata,
    input  logic [pcie_req_pkg::TAG_W-1:0]          dec_tag,
    output logic                                    dec_ready,

    output logic                                    cpl_valid,
    output logic [pcie_req_pkg::TAG_W-1:0]          cpl_tag,
    output logic [pcie_req_pkg::CPL_DATA_W-1:0]     cpl_data,
    input  logic                                    cpl_ready,

    output logic [led_pkg::LED_RGB_COUNT-1:0]       led_red,
    output logic [led_pkg::LED_RGB_COUNT-1:0]       led_green,
    output logic [led_pkg::LED_AUX_W-1:0]           led_bmc,
    output logic [led_pkg::LED_AUX_W-1:0]           led_exp
);

    import pcie_req_pkg::*;
    import led_pkg::*;

    logic                  dec_fire;
    logic [CPL_DATA_W-1:0] rd_data;

    // stall decode only while a completion is stuck at the sink
    assign dec_ready = !cpl_valid || cpl_ready;
    assign dec_fire  = dec_valid && dec_ready;

    // register write port, unmapped addresses fall through
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led_red   <= '0;
            led_green <= '0;
            led_bmc   <= '0;
            led_exp   <= '0;
        end else if (dec_fire && dec_write) begin
            case (dec_addr)
                ADDR_LED_RED:   led_red   <= dec_wdata[LED_RGB_COUNT-1:0];
                ADDR_LED_GREEN: led_green <= dec_wdata[LED_RGB_COUNT-1:0];
                ADDR_LED_BMC:   led_bmc   <= dec_wdata[LED_AUX_W-1:0];
                ADDR_LED_EXP:   led_exp   <= dec_wdata[LED_AUX_W-1:0];
                default: ;
            endcase
        end
    end

    // read port, zero-extended to the completion width
    always_comb begin
        case (dec_addr)
            ADDR_LED_RED:   rd_data = CPL_DATA_W'(led_red);
            ADDR_LED_GREEN: rd_data = CPL_DATA_W'(led_green);
            ADDR_LED_BMC:   rd_data = CPL_DATA_W'(led_bmc);
            ADDR_LED_EXP:   rd_data = CPL_DATA_W'(led_exp);
            default:        rd_data = '0;
        endcase
    end

    // completion holding register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cpl_valid <= 1'b0;
        end else if (dec_fire && !dec_write) begin
            cpl_valid <= 1'b1;
        end else if (cpl_ready) begin
            cpl_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_fire && !dec_write) begin
            cpl_tag  <= dec_tag;
            cpl_data <= rd_data;
        end
    end

endmodule

// ==== rtl/led_sreg_driver.sv ====
`timescale 1ns/1ps

module led_sreg_driver #(
    parameter int PRESCALE = 3,
    parameter int INVERT   = 1
) (
    input  logic                            clk,
    input  logic                            arst_n,

    input  logic [led_pkg::SREG_COUNT-1:0]  led,

    output logic                            sreg_d,
    output logic                            sreg_ld,
    output logic                            sreg_clk
);

    import led_pkg::*;

    // 16 bit periods plus one load period, two halves each
    localparam int HALF_COUNT = 2 * (SREG_COUNT + 1);
    localparam int HALF_W     = $clog2(HALF_COUNT);
    localparam int PRE_W      = $clog2(PRESCALE + 1);

    logic [PRE_W-1:0]      prescale_cnt;
    logic [HALF_W-1:0]     half_cnt;
    logic [HALF_W-1:0]     half_next;
    logic                  tick;
    logic                  load_next;
    logic [SREG_COUNT-1:0] shift_reg;

    assign tick      = prescale_cnt == PRE_W'(PRESCALE - 1);
    assign half_next = (half_cnt == HALF_W'(HALF_COUNT - 1)) ? '0 : half_cnt + 1'b1;
    assign load_next = half_next >= HALF_W'(2 * SREG_COUNT);

    // msb first, off level comes out of the all-zero reset value
    assign sreg_d = shift_reg[SREG_COUNT-1] ^ (INVERT != 0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prescale_cnt <= '0;
            // first tick wraps to half 0 and takes a snapshot
            half_cnt     <= HALF_W'(HALF_COUNT - 1);
            sreg_clk     <= 1'b0;
            sreg_ld      <= 1'b0;
            shift_reg    <= '0;
        end else if (tick) begin
            prescale_cnt <= '0;
            half_cnt     <= half_next;
            // odd halves of a bit period are the high phase
            sreg_clk     <= half_next[0] && !load_next;
            sreg_ld      <= load_next;
            if (half_next == '0) begin
                shift_reg <= led;
            end else if (!half_next[0] && !load_next) begin
                // next bit presented as the clock falls
                shift_reg <= shift_reg << 1;
            end
        end else begin
            prescale_cnt <= prescale_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/pcie_req_pkg.sv ====
package pcie_req_pkg;

    // request word and field widths
    localparam int REQ_W      = 32;
    localparam int TAG_W      = 8;
    localparam int ADDR_W     = 4;
    localparam int CPL_DATA_W = 16;

    // opcode in the top bit of every request word
    localparam logic OP_WRITE = 1'b1;
    localparam logic OP_READ  = 1'b0;

    // write view, address and data
    typedef struct packed {
        logic                                   op;
        logic [REQ_W-1-ADDR_W-CPL_DATA_W-1:0]   rsvd;
        logic [ADDR_W-1:0]                      addr;
        logic [CPL_DATA_W-1:0]                  wdata;
    } req_wr_t;

    // read view, tag and address, low half unused
    typedef struct packed {
        logic                                   op;
        logic [2:0]                             rsvd_hi;
        logic [TAG_W-1:0]                       tag;
        logic [ADDR_W-1:0]                      addr;
        logic [REQ_W-1-3-TAG_W-ADDR_W-1:0]      rsvd_lo;
    } req_rd_t;

    // one request word, decoded by its opcode
    typedef union packed {
        req_wr_t wr;
        req_rd_t rd;
    } req_word_u;

endpackage

// ==== rtl/req_decode.sv ====
`timescale 1ns/1ps

module req_decode (
    input  logic                                    clk,
    input  logic                                    arst_n,

    input  logic                                    req_valid,
    input  pcie_req_pkg::req_word_u                 req_data,
    output logic                                    req_ready,

    output logic                                    dec_valid,
    output logic                                    dec_write,
    output logic [pcie_req_pkg::ADDR_W-1:0]         dec_addr,
    output logic [pcie_req_pkg::CPL_DATA_W-1:0]     dec_wdata,
    output logic [pcie_req_pkg::TAG_W-1:0]          dec_tag,
    input  logic                                    dec_ready
);

    import pcie_req_pkg::*;

    req_word_u req_q;

    // single stage refills in the same cycle it drains
    assign req_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (req_ready) begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req_data;
        end
    end

    // address sits at the same bits in both views
    assign dec_addr = req_q.wr.addr;

    // opcode picks which view of the word is meaningful
    always_comb begin
        case (req_q.wr.op)
            OP_WRITE: begin
                dec_write = 1'b1;
                dec_wdata = req_q.wr.wdata;
                dec_tag   = '0;
            end
            OP_READ: begin
                dec_write = 1'b0;
                dec_wdata = '0;
                dec_tag   = req_q.rd.tag;
            end
            default: begin
                dec_write = 1'b0;
                dec_wdata = '0;
                dec_tag   = '0;
            end
        endcase
    end

endmodule

// ==== src.f ====
rtl/pcie_req_pkg.sv
rtl/led_pkg.sv
rtl/req_decode.sv
rtl/led_regs.sv
rtl/led_sreg_driver.sv
rtl/fpga.sv
tests/fpga_asserts.sv
tests/tb_fpga.sv

// ==== tests/fpga_asserts.sv ====
`timescale 1ns/1ps

module fpga_asserts #(
    parameter int PRESCALE = 3
) (
    input logic                                 clk,
    input logic                                 arst_n,
    input logic                                 req_ready,
    input logic                                 cpl_valid,
    input logic                                 cpl_ready,
    input logic [pcie_req_pkg::TAG_W-1:0]       cpl_tag,
    input logic [pcie_req_pkg::CPL_DATA_W-1:0]  cpl_data,
    input logic                                 led_sreg_d,
    input logic                                 led_sreg_ld,
    input logic                                 led_sreg_clk
);

    int ld_len;

    // clocks the load strobe has been high so far
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_len <= 0;
        end else if (led_sreg_ld) begin
            ld_len <= ld_len + 1;
        end else begin
            ld_len <= 0;
        end
    end

    cpl_hold: assert property (@(posedge clk) disable iff (!arst_n)
        cpl_valid && !cpl_ready |=> cpl_valid && $stable(cpl_tag) && $stable(cpl_data))
        else $error("completion changed while the sink stalled");

    ld_clk_low: assert property (@(posedge clk) disable iff (!arst_n)
        led_sreg_ld |-> !led_sreg_clk)
        else $error("load strobe high while sreg clock high");

    // one sreg clock period is two prescaled halves
    ld_one_period: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(led_sreg_ld) |-> ld_len == 2 * PRESCALE)
        else $error("load strobe length is not one sreg clock period");

    d_clk_low: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(led_sreg_d) |-> !led_sreg_clk)
        else $error("serial data moved while sreg clock high");

    ready_stall: assert property (@(posedge clk) disable iff (!arst_n)
        !req_ready |-> cpl_valid && !cpl_ready)
        else $error("request side stalled without completion back-pressure");

endmodule

bind fpga fpga_asserts #(.PRESCALE(PRESCALE)) asserts_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .req_ready    (req_ready),
    .cpl_valid    (cpl_valid),
    .cpl_ready    (cpl_ready),
    .cpl_tag      (cpl_tag),
    .cpl_data     (cpl_data),
    .led_sreg_d   (led_sreg_d),
    .led_sreg_ld  (led_sreg_ld),
    .led_sreg_clk (led_sreg_clk)
);

// ==== tests/tb_fpga.sv ====
`timescale 1ns/1ps

module tb_fpga;

    import pcie_req_pkg::*;
    import led_pkg::*;

    // roughly 1000 cycles of tests plus margin
    localparam int MAX_CYCLES = 4000;

    logic clk = 1'b0;
    logic arst_n;
    logic req_valid, req_ready, cpl_valid, cpl_ready, rand_cpl;
    req_word_u req_data;
    logic [TAG_W-1:0] cpl_tag;
    logic [CPL_DATA_W-1:0] cpl_data;
    logic [LED_AUX_W-1:0] led_bmc, led_exp;
    logic led_sreg_d, led_sreg_ld, led_sreg_clk;

    // register model and expected completions
    logic [LED_RGB_COUNT-1:0] m_red = '0, m_green = '0;
    logic [LED_AUX_W-1:0] m_bmc = '0, m_exp = '0;
    logic [TAG_W+CPL_DATA_W-1:0] cpl_q[$];
    logic [TAG_W+CPL_DATA_W-1:0] cpl_exp;
    logic [1:0] aux_vld = '0;
    logic [LED_AUX_W-1:0] aux_bmc[2], aux_exp[2];
    logic [SREG_COUNT-1:0] sreg_word, frame_expect;
    logic frame_armed = 1'b0;
    integer seed = 12790;
    int cycle_count = 0, req_count = 0, rgb_age = 100, sreg_bits = 0, frames_checked = 0;
    int gaps[40];
    logic [ADDR_W-1:0] rd_addr[40];

    fpga uut (.*);

    always #20 clk = ~clk;

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("[ERROR] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic req_word_u make_write(input logic [ADDR_W-1:0] addr,
                                             input logic [CPL_DATA_W-1:0] data);
        req_word_u w;
        w = '0;
        w.wr.op = OP_WRITE;
        w.wr.addr = addr;
        w.wr.wdata = data;
        return w;
    endfunction

    function automatic req_word_u make_read(input logic [ADDR_W-1:0] addr,
                                            input logic [TAG_W-1:0] tag);
        req_word_u w;
        w = '0;
        w.rd.op = OP_READ;
        w.rd.tag = tag;
        w.rd.addr = addr;
        return w;
    endfunction

    function automatic logic [CPL_DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
        case (addr)
            ADDR_LED_RED:   return CPL_DATA_W'(m_red);
            ADDR_LED_GREEN: return CPL_DATA_W'(m_green);
            ADDR_LED_BMC:   return CPL_DATA_W'(m_bmc);
            ADDR_LED_EXP:   return CPL_DATA_W'(m_exp);
            default:        return '0;
        endcase
    endfunction

    task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [CPL_DATA_W-1:0] d);
        case (addr)
            ADDR_LED_RED:   m_red = d[LED_RGB_COUNT-1:0];
            ADDR_LED_GREEN: m_green = d[LED_RGB_COUNT-1:0];
            ADDR_LED_BMC:   m_bmc = d[LED_AUX_W-1:0];
            ADDR_LED_EXP:   m_exp = d[LED_AUX_W-1:0];
            default: ;
        endcase
        if (addr == ADDR_LED_RED || addr == ADDR_LED_GREEN) begin
            rgb_age = 0;
        end
    endtask

    // red on even bits, green on odd bits
    function automatic logic [SREG_COUNT-1:0] interleave(input logic [LED_RGB_COUNT-1:0] red,
                                                        input logic [LED_RGB_COUNT-1:0] green);
        logic [SREG_COUNT-1:0] w;
        for (int i = 0; i < LED_RGB_COUNT; i++) begin
            w[2*i] = red[i];
            w[2*i+1] = green[i];
        end
        return w;
    endfunction

    task automatic send_req(input req_word_u word);
        int start;
        start = req_count;
        req_data = word;
        req_valid = 1'b1;
        @(negedge clk);
        while (req_count == start) @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (cpl_q.size() != 0 || cpl_valid) @(negedge clk);
    endtask

    // handshakes sampled at the same edge the DUT sees them
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", MAX_CYCLES);
            abort_run();
        end
        rgb_age = rgb_age + 1;
        if (aux_vld[1]) begin
            check_value("led_bmc", 32'(aux_bmc[1]), 32'(led_bmc));
            check_value("led_exp", 32'(aux_exp[1]), 32'(led_exp));
        end
        aux_vld[1] = aux_vld[0];
        aux_bmc[1] = aux_bmc[0];
        aux_exp[1] = aux_exp[0];
        aux_vld[0] = 1'b0;
        if (req_valid && req_ready) begin
            req_count = req_count + 1;
            if (req_data.wr.op == OP_WRITE) begin
                model_write(req_data.wr.addr, req_data.wr.wdata);
                aux_vld[0] = 1'b1;
                aux_bmc[0] = m_bmc;
                aux_exp[0] = m_exp;
            end else begin
                cpl_q.push_back({req_data.rd.tag, model_read(req_data.rd.addr)});
            end
        end
        if (cpl_valid && cpl_ready) begin
            assert (cpl_q.size() != 0) else begin
                $display("a completion arrived with no read outstanding");
                abort_run();
            end
            cpl_exp = cpl_q.pop_front();
            check_value("cpl_tag", 32'(cpl_exp[CPL_DATA_W +: TAG_W]), 32'(cpl_tag));
            check_value("cpl_data", 32'(cpl_exp[CPL_DATA_W-1:0]), 32'(cpl_data));
        end
    end

    always @(negedge clk) begin
        cpl_ready = rand_cpl ? (($random(seed) & 1) != 0) : 1'b1;
    end

    // shift register model, msb arrives first
    always @(posedge led_sreg_clk) begin
        sreg_word = {sreg_word[SREG_COUNT-2:0], led_sreg_d};
        sreg_bits = sreg_bits + 1;
    end

    // the driver takes its snapshot on the edge where the load strobe drops
    always @(negedge led_sreg_ld) begin
        frame_armed = arst_n && rgb_age >= 2;
        frame_expect = ~interleave(m_red, m_green);
        sreg_bits = 0;
    end

    always @(posedge led_sreg_ld) begin
        if (frame_armed) begin
            check_value("sreg bit count", 32'd16, 32'(sreg_bits));
            check_value("led_sreg_d frame", 32'(frame_expect), 32'(sreg_word));
            frames_checked = frames_checked + 1;
        end
    end

    initial begin
        arst_n = 1'b0;
        req_valid = 1'b0;
        req_data = '0;
        cpl_ready = 1'b1;
        rand_cpl = 1'b0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("cpl_valid", 32'd0, 32'(cpl_valid));
        check_value("led_sreg_ld", 32'd0, 32'(led_sreg_ld));
        check_value("led_sreg_d", 32'd1, 32'(led_sreg_d));
        check_value("led_bmc", 32'd0, 32'(led_bmc));
        check_value("led_exp", 32'd0, 32'(led_exp));
        check_value("req_ready", 32'd1, 32'(req_ready));

        // each mapped register, write then read back
        for (int a = 0; a < 4; a++) begin
            send_req(make_write(ADDR_W'(a), CPL_DATA_W'($random(seed))));
            send_req(make_read(ADDR_W'(a), TAG_W'(8'h40 + a)));
        end
        wait_drained();

        // unmapped space reads as zero and leaves the map alone
        for (int a = 4; a < 16; a++) begin
            send_req(make_write(ADDR_W'(a), 16'hffff));
        end
        for (int a = 0; a < 16; a++) begin
            send_req(make_read(ADDR_W'(a), TAG_W'(8'h80 + a)));
        end
        wait_drained();

        // new colours, then a few full frames on the chain
        repeat (2) begin
            send_req(make_write(ADDR_LED_RED, CPL_DATA_W'($random(seed))));
            send_req(make_write(ADDR_LED_GREEN, CPL_DATA_W'($random(seed))));
            repeat (3) @(posedge led_sreg_ld);
            @(negedge clk);
        end

        // back-to-back reads against a stalling sink
        for (int i = 0; i < 40; i++) begin
            gaps[i] = $unsigned($random(seed)) % 3;
            rd_addr[i] = ADDR_W'($unsigned($random(seed)) % 6);
        end
        rand_cpl = 1'b1;
        for (int i = 0; i < 40; i++) begin
            repeat (gaps[i]) @(negedge clk);
            send_req(make_read(rd_addr[i], TAG_W'(i)));
        end
        rand_cpl = 1'b0;
        wait_drained();

        if (cpl_q.size() == 0 && frames_checked > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("completions are missing or no serial frame was checked");
            abort_run();
        end
    end

endmodule
